// File: include/dma_xif_config.svh
// widths, instruction fields, opcodes and register map of the dma issue front end; include where needed
`ifndef DMA_XIF_CONFIG_SVH
`define DMA_XIF_CONFIG_SVH

// data path widths
`define DMA_DATA_W        32
`define DMA_ADDR_W        32
`define DMA_INSTR_W       32

// instruction field widths and offsets
`define DMA_OPCODE_W      7
`define DMA_FUNC3_W       3
`define DMA_CONF_OFF      7   // first option bit of a CONF instruction
`define DMA_FUNC3_OFF     12

// custom-0 and custom-1 opcode space
`define DMA_CONF_OPCODE   7'h0B
`define DMA_SET_OPCODE    7'h2B

// func3 codes of the SET instruction
`define DMA_SET_DA_FUNC3  3'b000
`define DMA_SET_SA_FUNC3  3'b001
`define DMA_SET_L_FUNC3   3'b010
`define DMA_SET_S_FUNC3   3'b110

// packed transfer options, nd_en sits at bit 0
`define DMA_CONF_W        11
`define DMA_MAX_LOG_LEN_W 3

// register front end byte addresses
`define DMA_REG_CONF      32'h0000_0000
`define DMA_REG_DST_ADDR  32'h0000_0004
`define DMA_REG_SRC_ADDR  32'h0000_0008
`define DMA_REG_LENGTH    32'h0000_000C
`define DMA_REG_NEXT_ID   32'h0000_0010

`define DMA_N_STEPS       4   // register writes per launch

`endif

// File: logic/dma_xif_pkg.sv
// shared types of the dma issue front end, referenced by scoped name from the rtl and testbench
package dma_xif_pkg;

  `include "dma_xif_config.svh"

  // transfer options as they sit in the CONF immediate, lsb last
  typedef struct packed {
    logic                          decouple_r_aw;
    logic                          decouple_r_w;
    logic                          src_reduce_len;
    logic                          dst_reduce_len;
    logic [`DMA_MAX_LOG_LEN_W-1:0] src_max_log_len;
    logic [`DMA_MAX_LOG_LEN_W-1:0] dst_max_log_len;
    logic                          nd_en;
  } dma_conf_t;

  typedef struct packed {
    logic [`DMA_INSTR_W-`DMA_CONF_OFF-`DMA_CONF_W-1:0] pad;
    dma_conf_t                                         opts;
    logic [`DMA_OPCODE_W-1:0]                          opcode;
  } dma_conf_instr_t;

  // plain r-type layout
  typedef struct packed {
    logic [6:0]                             funct7;
    logic [4:0]                             rs2;
    logic [4:0]                             rs1;
    logic [`DMA_FUNC3_W-1:0]                func3;
    logic [`DMA_FUNC3_OFF-`DMA_OPCODE_W-1:0] rd;
    logic [`DMA_OPCODE_W-1:0]               opcode;
  } dma_set_instr_t;

  // one issued word, read as CONF or as SET
  typedef union packed {
    dma_conf_instr_t conf;
    dma_set_instr_t  set;
  } dma_instr_u;

  // config bank index, equal to the launch step number
  typedef logic [1:0] cfg_idx_t;

  localparam cfg_idx_t CFG_CONF = 2'd0;
  localparam cfg_idx_t CFG_DST  = 2'd1;
  localparam cfg_idx_t CFG_SRC  = 2'd2;
  localparam cfg_idx_t CFG_LEN  = 2'd3;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    START,
    BUSY,
    DONE
  } dma_state_e;

endpackage

// File: logic/dma_cmd_decoder.sv
// issue port decoder, accepts CONF and SET instructions and keeps the launch config bank
`timescale 1ns/10ps

`include "dma_xif_config.svh"

module dma_cmd_decoder (
  input  logic                    clk_cfg_g,
  input  logic                    rst_ni,
  input  logic                    clear_i,

  input  logic                    issue_valid_i,
  input  dma_xif_pkg::dma_instr_u instr_i,
  input  logic [`DMA_DATA_W-1:0]  rs0_i,

  input  dma_xif_pkg::cfg_idx_t   step_idx_i,   // word read out by the launch

  output logic                    issue_ready_o,
  output logic                    issue_accept_o,
  output logic                    start_req_o,
  output logic [`DMA_DATA_W-1:0]  cfg_word_o
);

  logic                   is_conf;
  logic                   is_set;
  logic                   bank_we;
  dma_xif_pkg::cfg_idx_t  bank_idx;
  logic [`DMA_DATA_W-1:0] bank_wdata;

  // conf, dst, src, len
  logic [`DMA_DATA_W-1:0] cfg_bank_q [`DMA_N_STEPS];

  // both views carry the opcode in the same bits
  assign is_conf = (instr_i.conf.opcode == `DMA_CONF_OPCODE);
  assign is_set  = (instr_i.set.opcode == `DMA_SET_OPCODE);

  // every known opcode is taken at once, nothing is ever stalled
  assign issue_ready_o  = issue_valid_i & (is_conf | is_set);
  assign issue_accept_o = issue_ready_o;

  always_comb begin
    bank_we     = 1'b0;
    bank_idx    = dma_xif_pkg::CFG_CONF;
    bank_wdata  = rs0_i;
    start_req_o = 1'b0;

    if (issue_valid_i) begin
      if (is_conf) begin
        bank_we    = 1'b1;
        bank_idx   = dma_xif_pkg::CFG_CONF;
        bank_wdata = `DMA_DATA_W'(instr_i.conf.opts);  // options zero-extended
      end else if (is_set) begin
        case (instr_i.set.func3)
          `DMA_SET_DA_FUNC3: begin
            bank_we  = 1'b1;
            bank_idx = dma_xif_pkg::CFG_DST;
          end
          `DMA_SET_SA_FUNC3: begin
            bank_we  = 1'b1;
            bank_idx = dma_xif_pkg::CFG_SRC;
          end
          `DMA_SET_L_FUNC3: begin
            bank_we  = 1'b1;
            bank_idx = dma_xif_pkg::CFG_LEN;
          end
          `DMA_SET_S_FUNC3: begin
            start_req_o = 1'b1;  // launch request, bank untouched
          end
          default: begin
            bank_we = 1'b0;  // unknown func3 is accepted and dropped
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_cfg_g, negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_bank_q <= '{default: '0};
    end else if (clear_i) begin
      cfg_bank_q <= '{default: '0};
    end else if (bank_we) begin
      cfg_bank_q[bank_idx] <= bank_wdata;
    end
  end

  // step number doubles as bank index
  assign cfg_word_o = cfg_bank_q[step_idx_i];

endmodule

// File: logic/cfg_step_counter.sv
// step counter for the launch write sequence, gives the bank index and target register address
`timescale 1ns/10ps

`include "dma_xif_config.svh"

module cfg_step_counter (
  input  logic                   clk_cfg_g,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   step_clr_i,   // back to the first write
  input  logic                   step_inc_i,   // one write completed

  output dma_xif_pkg::cfg_idx_t  step_idx_o,
  output logic                   step_last_o,
  output logic [`DMA_ADDR_W-1:0] step_addr_o
);

  dma_xif_pkg::cfg_idx_t step_q;

  always_ff @(posedge clk_cfg_g, negedge rst_ni) begin
    if (!rst_ni) begin
      step_q <= dma_xif_pkg::CFG_CONF;
    end else if (clear_i || step_clr_i) begin
      step_q <= dma_xif_pkg::CFG_CONF;
    end else if (step_inc_i) begin
      step_q <= step_q + 2'd1;  // wraps after the length write
    end
  end

  assign step_idx_o  = step_q;
  assign step_last_o = (step_q == dma_xif_pkg::cfg_idx_t'(`DMA_N_STEPS - 1));

  // register order of one launch
  always_comb begin
    case (step_q)
      dma_xif_pkg::CFG_CONF: step_addr_o = `DMA_REG_CONF;
      dma_xif_pkg::CFG_DST:  step_addr_o = `DMA_REG_DST_ADDR;
      dma_xif_pkg::CFG_SRC:  step_addr_o = `DMA_REG_SRC_ADDR;
      default:               step_addr_o = `DMA_REG_LENGTH;
    endcase
  end

endmodule

// File: logic/dma_ctrl_fsm.sv
// launch FSM, writes the config bank to the dma registers and polls the transfer id
`timescale 1ns/10ps

`include "dma_xif_config.svh"

module dma_ctrl_fsm (
  input  logic                   clk_cfg_g,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   start_req_i,

  input  logic [`DMA_DATA_W-1:0] cfg_word_i,
  input  logic [`DMA_ADDR_W-1:0] step_addr_i,
  input  logic                   step_last_i,

  output logic                   step_clr_o,
  output logic                   step_inc_o,

  // dma register front end
  output logic                   reg_valid_o,
  output logic                   reg_write_o,
  output logic [`DMA_ADDR_W-1:0] reg_addr_o,
  output logic [`DMA_DATA_W-1:0] reg_wdata_o,
  input  logic                   reg_ready_i,
  input  logic                   reg_error_i,
  input  logic [`DMA_DATA_W-1:0] reg_rdata_i,

  output logic                   start_o,  // reading the first id
  output logic                   busy_o,   // waiting for the id to move on
  output logic                   done_o,   // one cycle at the end of a launch
  output logic                   error_o   // bus error or zero id
);

  dma_xif_pkg::dma_state_e state_q;
  dma_xif_pkg::dma_state_e state_d;

  logic [`DMA_DATA_W-1:0] id_q;
  logic [`DMA_DATA_W-1:0] id_d;

  always_comb begin
    state_d     = state_q;
    id_d        = id_q;
    step_clr_o  = 1'b0;
    step_inc_o  = 1'b0;
    reg_valid_o = 1'b0;
    reg_write_o = 1'b0;
    reg_addr_o  = '0;
    reg_wdata_o = '0;
    error_o     = 1'b0;

    case (state_q)
      dma_xif_pkg::IDLE: begin
        step_clr_o = 1'b1;  // every launch starts at the conf write
        if (start_req_i) begin
          state_d = dma_xif_pkg::WRITE;
        end
      end

      dma_xif_pkg::WRITE: begin
        reg_valid_o = 1'b1;
        reg_write_o = 1'b1;
        reg_addr_o  = step_addr_i;
        reg_wdata_o = cfg_word_i;
        if (reg_error_i) begin
          error_o = 1'b1;
          state_d = dma_xif_pkg::IDLE;
        end else if (reg_ready_i) begin
          step_inc_o = 1'b1;
          if (step_last_i) begin
            state_d = dma_xif_pkg::START;
          end
        end
      end

      dma_xif_pkg::START: begin
        reg_valid_o = 1'b1;
        reg_addr_o  = `DMA_REG_NEXT_ID;
        if (reg_error_i) begin
          error_o = 1'b1;
          state_d = dma_xif_pkg::IDLE;
        end else if (reg_ready_i) begin
          if (reg_rdata_i == '0) begin
            // transfer was not set up properly
            error_o = 1'b1;
            state_d = dma_xif_pkg::IDLE;
          end else begin
            id_d    = reg_rdata_i;
            state_d = dma_xif_pkg::BUSY;
          end
        end
      end

      dma_xif_pkg::BUSY: begin
        reg_valid_o = 1'b1;
        reg_addr_o  = `DMA_REG_NEXT_ID;
        if (reg_error_i) begin
          error_o = 1'b1;
          state_d = dma_xif_pkg::IDLE;
        end else if (reg_ready_i && (reg_rdata_i != id_q)) begin
          state_d = dma_xif_pkg::DONE;  // id moved on, our transfer is retired
        end
      end

      dma_xif_pkg::DONE: begin
        state_d = dma_xif_pkg::IDLE;
      end

      default: begin
        state_d = dma_xif_pkg::IDLE;
      end
    endcase
  end

  assign start_o = (state_q == dma_xif_pkg::START);
  assign busy_o  = (state_q == dma_xif_pkg::BUSY);
  assign done_o  = (state_q == dma_xif_pkg::DONE);

  always_ff @(posedge clk_cfg_g, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dma_xif_pkg::IDLE;
    end else if (clear_i) begin
      state_q <= dma_xif_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // id of the launched transfer
  always_ff @(posedge clk_cfg_g, negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (clear_i) begin
      id_q <= '0;
    end else begin
      id_q <= id_d;
    end
  end

endmodule

// File: logic/dma_xif_frontend.sv
// top of the dma issue front end, connects decoder, step counter and launch FSM
`timescale 1ns/10ps

`include "dma_xif_config.svh"

module dma_xif_frontend (
  input  logic                    clk_cfg_g,
  input  logic                    rst_ni,
  input  logic                    clear_i,

  // cpu issue port
  input  logic                    issue_valid_i,
  input  dma_xif_pkg::dma_instr_u instr_i,
  input  logic [`DMA_DATA_W-1:0]  rs0_i,
  output logic                    issue_ready_o,
  output logic                    issue_accept_o,

  // dma register front end
  output logic                    reg_valid_o,
  output logic                    reg_write_o,
  output logic [`DMA_ADDR_W-1:0]  reg_addr_o,
  output logic [`DMA_DATA_W-1:0]  reg_wdata_o,
  input  logic                    reg_ready_i,
  input  logic                    reg_error_i,
  input  logic [`DMA_DATA_W-1:0]  reg_rdata_i,

  // launch status
  output logic                    start_o,
  output logic                    busy_o,
  output logic                    done_o,
  output logic                    error_o
);

  logic                   start_req;
  logic                   step_clr;
  logic                   step_inc;
  logic                   step_last;
  logic [`DMA_ADDR_W-1:0] step_addr;
  dma_xif_pkg::cfg_idx_t  step_idx;
  logic [`DMA_DATA_W-1:0] cfg_word;

  dma_cmd_decoder decoder_i (
    .clk_cfg_g      (clk_cfg_g),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .issue_valid_i  (issue_valid_i),
    .instr_i        (instr_i),
    .rs0_i          (rs0_i),
    .step_idx_i     (step_idx),
    .issue_ready_o  (issue_ready_o),
    .issue_accept_o (issue_accept_o),
    .start_req_o    (start_req),
    .cfg_word_o     (cfg_word)
  );

  cfg_step_counter step_i (
    .clk_cfg_g   (clk_cfg_g),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .step_clr_i  (step_clr),
    .step_inc_i  (step_inc),
    .step_idx_o  (step_idx),
    .step_last_o (step_last),
    .step_addr_o (step_addr)
  );

  dma_ctrl_fsm fsm_i (
    .clk_cfg_g   (clk_cfg_g),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .start_req_i (start_req),
    .cfg_word_i  (cfg_word),
    .step_addr_i (step_addr),
    .step_last_i (step_last),
    .step_clr_o  (step_clr),
    .step_inc_o  (step_inc),
    .reg_valid_o (reg_valid_o),
    .reg_write_o (reg_write_o),
    .reg_addr_o  (reg_addr_o),
    .reg_wdata_o (reg_wdata_o),
    .reg_ready_i (reg_ready_i),
    .reg_error_i (reg_error_i),
    .reg_rdata_i (reg_rdata_i),
    .start_o     (start_o),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .error_o     (error_o)
  );

endmodule

// File: verification/dma_reg_model.sv
// behavioral dma register front end for the testbench, with ready delay, write log and id counter
`timescale 1ns/10ps

`include "dma_xif_config.svh"

module dma_reg_model (
  input  logic                   clk_cfg_g,
  input  logic                   rst_ni,
  input  logic                   log_clr_i,   // empties the log and the poll count
  input  logic [1:0]             delay_i,     // wait cycles before ready
  input  logic [3:0]             polls_i,     // id reads before the id moves on
  input  logic                   zero_id_i,
  input  logic                   err_en_i,
  input  logic [`DMA_ADDR_W-1:0] err_addr_i,

  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  logic [`DMA_ADDR_W-1:0] reg_addr_i,
  input  logic [`DMA_DATA_W-1:0] reg_wdata_i,
  output logic                   reg_ready_o,
  output logic                   reg_error_o,
  output logic [`DMA_DATA_W-1:0] reg_rdata_o
);

  logic [1:0]             wait_q;
  logic [3:0]             rd_cnt_q;
  logic [`DMA_DATA_W-1:0] next_id_q;
  logic                   xfer;

  // completed writes, read by the testbench compare process
  logic [`DMA_ADDR_W-1:0] log_addr [16];
  logic [`DMA_DATA_W-1:0] log_data [16];
  logic [4:0]             log_n;

  assign reg_ready_o = reg_valid_i && (wait_q >= delay_i);
  assign reg_error_o = reg_valid_i && err_en_i && (reg_addr_i == err_addr_i);
  assign reg_rdata_o = zero_id_i ? '0 : next_id_q;
  assign xfer        = reg_ready_o && !reg_error_o;

  always @(posedge clk_cfg_g or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q    <= '0;
      rd_cnt_q  <= '0;
      next_id_q <= 32'd5;  // any nonzero start id
      log_n     <= '0;
    end else begin
      if (!reg_valid_i || reg_ready_o) begin
        wait_q <= '0;
      end else if (wait_q != 2'd3) begin
        wait_q <= wait_q + 2'd1;
      end

      if (log_clr_i) begin
        log_n    <= '0;
        rd_cnt_q <= '0;
      end else if (xfer && reg_write_i) begin
        if (!log_n[4]) begin
          log_addr[log_n[3:0]] <= reg_addr_i;
          log_data[log_n[3:0]] <= reg_wdata_i;
          log_n                <= log_n + 5'd1;
        end
      end else if (xfer && (reg_addr_i == `DMA_REG_NEXT_ID)) begin
        if (rd_cnt_q + 4'd1 >= polls_i) begin
          rd_cnt_q  <= '0;
          next_id_q <= next_id_q + 32'd1;  // current transfer retires
        end else begin
          rd_cnt_q <= rd_cnt_q + 4'd1;
        end
      end
    end
  end

endmodule

// File: verification/tb_dma_xif_frontend.sv
// testbench top for the dma issue front end, drives the issue port and checks bus writes and status
`timescale 1ns/10ps

`include "dma_xif_config.svh"

module tb_dma_xif_frontend;

  localparam int TESTS         = 6;
  localparam int LAUNCH_CYCLES = 48;  // 3 cycle ready delay on every transfer and 3 polls
  localparam int WATCHDOG_NS   = TESTS * 3 * LAUNCH_CYCLES * 4 + 400;

  logic                    clk_cfg_g;
  logic                    rst_ni;
  logic                    clear_i;
  logic                    issue_valid;
  dma_xif_pkg::dma_instr_u instr;
  logic [`DMA_DATA_W-1:0]  rs0;
  logic                    issue_ready;
  logic                    issue_accept;
  logic                    reg_valid;
  logic                    reg_write;
  logic [`DMA_ADDR_W-1:0]  reg_addr;
  logic [`DMA_DATA_W-1:0]  reg_wdata;
  logic                    reg_ready;
  logic                    reg_error;
  logic [`DMA_DATA_W-1:0]  reg_rdata;
  logic                    start_s;
  logic                    busy_s;
  logic                    done_s;
  logic                    error_s;

  // model controls
  logic                    log_clr;
  logic [1:0]              ready_delay;
  logic [3:0]              polls;
  logic                    zero_id;
  logic                    err_en;
  logic [`DMA_ADDR_W-1:0]  err_addr;
  logic                    bp_en;

  logic [31:0]             rng_state = 32'd89;
  logic [10:0]             exp_opts;  // values issued since the last clear
  logic [`DMA_DATA_W-1:0]  exp_dst;
  logic [`DMA_DATA_W-1:0]  exp_src;
  logic [`DMA_DATA_W-1:0]  exp_len;
  logic [63:0]             exp_w;
  logic [4:0]              chk_n = '0;
  int                      cmp_errs = 0;
  int                      err_cnt;
  int                      test_errs;
  int                      test_fails;

  dma_xif_frontend dut_i (
    .clk_cfg_g      (clk_cfg_g),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .issue_valid_i  (issue_valid),
    .instr_i        (instr),
    .rs0_i          (rs0),
    .issue_ready_o  (issue_ready),
    .issue_accept_o (issue_accept),
    .reg_valid_o    (reg_valid),
    .reg_write_o    (reg_write),
    .reg_addr_o     (reg_addr),
    .reg_wdata_o    (reg_wdata),
    .reg_ready_i    (reg_ready),
    .reg_error_i    (reg_error),
    .reg_rdata_i    (reg_rdata),
    .start_o        (start_s),
    .busy_o         (busy_s),
    .done_o         (done_s),
    .error_o        (error_s)
  );

  dma_reg_model model_i (
    .clk_cfg_g   (clk_cfg_g),
    .rst_ni      (rst_ni),
    .log_clr_i   (log_clr),
    .delay_i     (ready_delay),
    .polls_i     (polls),
    .zero_id_i   (zero_id),
    .err_en_i    (err_en),
    .err_addr_i  (err_addr),
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_ready_o (reg_ready),
    .reg_error_o (reg_error),
    .reg_rdata_o (reg_rdata)
  );

  initial begin
    clk_cfg_g = 1'b0;
    forever #2 clk_cfg_g = ~clk_cfg_g;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state ^ (rng_state >> 16);
  endfunction

  // CONF puts the options right above the opcode, SET is r-type with func3 at 14:12
  function automatic logic [31:0] conf_word(input logic [10:0] opts);
    return {14'b0, opts, `DMA_CONF_OPCODE};
  endfunction

  function automatic logic [31:0] set_word(input logic [2:0] f3);
    return {17'b0, f3, 5'b0, `DMA_SET_OPCODE};
  endfunction

  // expected address and data of launch write k
  function automatic logic [63:0] ref_write(input int k);
    case (k)
      0:       return {`DMA_REG_CONF, 21'b0, exp_opts};
      1:       return {`DMA_REG_DST_ADDR, exp_dst};
      2:       return {`DMA_REG_SRC_ADDR, exp_src};
      default: return {`DMA_REG_LENGTH, exp_len};
    endcase
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
    err_cnt++;
  endtask

  task automatic flag_problem(input string msg);
    $display("error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // checks every new entry of the model's write log
  always @(negedge clk_cfg_g) begin
    if (model_i.log_n < chk_n) begin
      chk_n = '0;  // log was emptied
    end
    while (chk_n < model_i.log_n) begin
      if (chk_n >= `DMA_N_STEPS) begin
        $display("error at %0t: more than four writes in one launch", $time);
        cmp_errs++;
      end else begin
        exp_w = ref_write(int'(chk_n));
        if (model_i.log_addr[chk_n[3:0]] !== exp_w[63:32]) begin
          $display("FAILED at %0t: reg_addr_o expected %h got %h", $time, exp_w[63:32],
                   model_i.log_addr[chk_n[3:0]]);
          cmp_errs++;
        end
        if (model_i.log_data[chk_n[3:0]] !== exp_w[31:0]) begin
          $display("FAILED at %0t: reg_wdata_o expected %h got %h", $time, exp_w[31:0],
                   model_i.log_data[chk_n[3:0]]);
          cmp_errs++;
        end
      end
      chk_n = chk_n + 5'd1;
    end
  end

  task automatic issue_instr(input logic [31:0] word, input logic [31:0] value);
    issue_valid = 1'b1;
    instr       = word;
    rs0         = value;
    @(posedge clk_cfg_g);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic check_accept(input logic [31:0] word, input logic valid);
    logic exp_ok;
    exp_ok      = valid && (word[6:0] == `DMA_CONF_OPCODE || word[6:0] == `DMA_SET_OPCODE);
    issue_valid = valid;
    instr       = word;
    rs0         = lcg_next();
    @(negedge clk_cfg_g);
    if (issue_ready !== exp_ok) flag_mismatch("issue_ready_o", 32'(exp_ok), 32'(issue_ready));
    if (issue_accept !== exp_ok) flag_mismatch("issue_accept_o", 32'(exp_ok), 32'(issue_accept));
    @(posedge clk_cfg_g);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic configure_random();
    exp_opts = 11'(lcg_next());
    exp_dst  = lcg_next();
    exp_src  = lcg_next();
    exp_len  = lcg_next();
    issue_instr(conf_word(exp_opts), 32'd0);
    issue_instr(set_word(`DMA_SET_DA_FUNC3), exp_dst);
    issue_instr(set_word(`DMA_SET_SA_FUNC3), exp_src);
    issue_instr(set_word(`DMA_SET_L_FUNC3), exp_len);
  endtask

  task automatic clear_log();
    log_clr = 1'b1;
    @(posedge clk_cfg_g);
    #1;
    log_clr = 1'b0;
  endtask

  // start a launch and follow its status until done_o or error_o
  task automatic run_launch(input logic expect_done, input int exp_writes);
    int   cyc;
    int   done_cyc;
    logic seen_start;
    logic seen_busy;
    logic seen_err;
    logic finished;
    logic id_moved;
    logic [`DMA_DATA_W-1:0] first_id;
    cyc        = 0;
    done_cyc   = 0;
    seen_start = 1'b0;
    seen_busy  = 1'b0;
    seen_err   = 1'b0;
    finished   = 1'b0;
    id_moved   = 1'b0;
    first_id   = '0;
    clear_log();
    issue_instr(set_word(`DMA_SET_S_FUNC3), 32'd0);
    while (!finished && cyc < LAUNCH_CYCLES) begin
      @(negedge clk_cfg_g);
      if (busy_s && !seen_start) flag_problem("busy_o raised before start_o");
      if (start_s) seen_start = 1'b1;
      if (busy_s) seen_busy = 1'b1;
      if (error_s) seen_err = 1'b1;
      if (done_s) done_cyc++;
      if (start_s && reg_ready && !reg_error) first_id = reg_rdata;  // id of this launch
      if (busy_s && reg_ready && !reg_error && reg_rdata != first_id) id_moved = 1'b1;
      if (done_s && !id_moved) flag_problem("done_o before the transfer id moved on");
      finished = done_s || error_s;
      @(posedge clk_cfg_g);
      #1;
      ready_delay = bp_en ? 2'(lcg_next()) : 2'd0;
      cyc++;
    end
    @(negedge clk_cfg_g);
    if (done_s) done_cyc++;  // done_o must be gone again
    if (busy_s) seen_busy = 1'b1;
    if (!finished) begin
      flag_problem("launch ended with neither done_o nor error_o");
    end else if (expect_done) begin
      if (!seen_start || !seen_busy) flag_problem("start_o or busy_o never seen");
      if (seen_err) flag_problem("error_o pulsed in a good launch");
      if (done_cyc != 1) flag_mismatch("done_o cycles", 32'd1, done_cyc);
    end else begin
      if (!seen_err) flag_problem("no error_o pulse in a failing launch");
      if (seen_busy || done_cyc != 0) flag_problem("busy_o or done_o after an error");
    end
    if (int'(model_i.log_n) != exp_writes) flag_mismatch("write count", exp_writes,
                                                         32'(model_i.log_n));
  endtask

  task automatic finish_test(input string name);
    if (err_cnt + cmp_errs == test_errs) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, err_cnt + cmp_errs - test_errs);
      test_fails++;
    end
    test_errs = err_cnt + cmp_errs;
  endtask

  initial begin
    logic [31:0] w;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    issue_valid = 1'b0;
    instr       = '0;
    rs0         = '0;
    log_clr     = 1'b0;
    ready_delay = 2'd0;
    polls       = 4'd2;
    zero_id     = 1'b0;
    err_en      = 1'b0;
    err_addr    = '0;
    bp_en       = 1'b0;
    exp_opts    = '0;
    exp_dst     = '0;
    exp_src     = '0;
    exp_len     = '0;
    err_cnt     = 0;
    test_errs   = 0;
    test_fails  = 0;
    repeat (2) @(posedge clk_cfg_g);
    #1;
    rst_ni = 1'b1;

    check_accept(conf_word(11'h5a5), 1'b1);
    check_accept(set_word(`DMA_SET_DA_FUNC3), 1'b1);
    check_accept(conf_word(11'h0ff), 1'b0);
    repeat (6) begin
      w = lcg_next();
      if (w[6:0] == `DMA_CONF_OPCODE || w[6:0] == `DMA_SET_OPCODE) w[6:0] = 7'h33;
      check_accept(w, 1'b1);
    end
    finish_test("issue acceptance");

    configure_random();
    run_launch(1'b1, 4);
    finish_test("write sequence");

    bp_en = 1'b1;  // random ready delay from here
    repeat (2) begin
      configure_random();
      run_launch(1'b1, 4);
    end
    bp_en       = 1'b0;
    ready_delay = 2'd0;
    finish_test("back-pressure");

    polls = 4'd3;
    configure_random();
    run_launch(1'b1, 4);
    finish_test("launch status");

    zero_id = 1'b1;
    run_launch(1'b0, 4);
    zero_id  = 1'b0;
    err_en   = 1'b1;
    err_addr = `DMA_REG_SRC_ADDR;
    run_launch(1'b0, 2);  // conf and dst land, src fails
    err_en = 1'b0;
    run_launch(1'b1, 4);
    finish_test("errors");

    configure_random();
    ready_delay = 2'd3;
    clear_log();
    issue_instr(set_word(`DMA_SET_S_FUNC3), 32'd0);
    repeat (4) begin
      @(posedge clk_cfg_g);
      #1;
    end
    @(negedge clk_cfg_g);
    if (!reg_valid) flag_problem("no launch in progress before clear_i");
    @(posedge clk_cfg_g);
    #1;
    clear_i = 1'b1;
    @(posedge clk_cfg_g);
    #1;
    clear_i = 1'b0;
    repeat (4) begin
      @(negedge clk_cfg_g);
      if (reg_valid) flag_problem("bus request after clear_i");
      if (done_s) flag_problem("done_o after clear_i");
      @(posedge clk_cfg_g);
      #1;
    end
    exp_opts    = '0;  // bank was zeroed
    exp_dst     = '0;
    exp_src     = '0;
    exp_len     = '0;
    ready_delay = 2'd0;
    run_launch(1'b1, 4);
    finish_test("clear");

    $display("%0d tests run, %0d failed, %0d errors", TESTS, test_fails, err_cnt + cmp_errs);
    if (err_cnt + cmp_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: dma_xif_frontend.f
+incdir+include
logic/dma_xif_pkg.sv
logic/dma_cmd_decoder.sv
logic/cfg_step_counter.sv
logic/dma_ctrl_fsm.sv
logic/dma_xif_frontend.sv
verification/dma_reg_model.sv
verification/tb_dma_xif_frontend.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_dma_xif_frontend
FILELIST  := dma_xif_frontend.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q -F "** PASS **" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
